/* list.f */
+incdir+hw
hw/xpu_pkg.sv
hw/rx_header_parse.sv
hw/rx_frame_filter.sv
hw/rx_frame_report.sv
hw/tsf_timer.sv
hw/xpu_rx.sv
sim/xpu_rx_properties.sv
sim/xpu_rx_tb.sv

/* sim/xpu_rx_tb.sv */
// xpu receive path testbench
`timescale 1ns/1ps
`include "xpu_defs.svh"

module xpu_rx_tb;

    localparam int n_frames = 150;
    localparam int max_frame_cycles = 128;
    localparam int tsf_cycles = 800;
    localparam int watchdog_ns = (3 * n_frames * max_frame_cycles + tsf_cycles) * 4 * 2;

    logic                       clk = 1'b0;
    logic                       reset_i;
    logic                       header_strobe_i;
    logic [`XPU_BYTE_IDX_W-1:0] pkt_len_i;
    logic                       byte_strobe_i;
    logic [7:0]                 byte_i;
    logic [`XPU_BYTE_IDX_W-1:0] byte_index_i;
    logic                       fcs_strobe_i;
    logic                       fcs_ok_i;
    xpu_pkg::mac_addr_t         self_mac_i;
    xpu_pkg::mac_addr_t         self_bssid_i;
    logic [`XPU_FILTER_W-1:0]   filter_cfg_i;
    logic [`XPU_BYTE_IDX_W-1:0] max_len_i;
    logic                       tsf_load_i;
    xpu_pkg::tsf_t              tsf_load_val_i;
    xpu_pkg::fc_word_u          fc_o;
    logic                       fc_valid_o;
    xpu_pkg::mac_addr_t         addr1_o;
    xpu_pkg::mac_addr_t         addr2_o;
    xpu_pkg::mac_addr_t         addr3_o;
    logic                       addr1_valid_o;
    logic                       addr2_valid_o;
    logic                       addr3_valid_o;
    logic                       verdict_valid_o;
    logic                       verdict_block_o;
    logic                       pkt_for_me_o;
    logic                       report_valid_o;
    logic                       report_ok_o;
    logic                       report_block_o;
    xpu_pkg::tsf_t              report_tsf_o;
    xpu_pkg::tsf_t              tsf_o;
    logic                       tsf_pulse_o;

    xpu_rx i_xpu_rx (.*);

    always #2 clk = ~clk;

    logic [31:0] lfsr = 32'd22;
    int n_checks = 0;
    int n_errors = 0;
    int n_tests = 0;
    int n_assert_fails = 0;
    int cycle = 0;

    // current frame as generated
    xpu_pkg::fc_word_u  f_fc;
    xpu_pkg::mac_addr_t f_a1;
    xpu_pkg::mac_addr_t f_a2;
    xpu_pkg::mac_addr_t f_a3;
    logic               f_block;

    // reference model state
    logic               m_fc_seen = 0;
    logic               m_is_ctrl = 0;
    logic               m_decided = 0;
    logic               m_vv_pend = 0;
    logic               m_has_verdict = 0;
    logic               m_vblock = 0;
    logic               m_a1_seen = 0;
    xpu_pkg::mac_addr_t m_a1 = '0;
    xpu_pkg::tsf_t      m_stamp = '0;
    xpu_pkg::tsf_t      m_tsf = '0;
    int                 m_div = 0;
    logic               m_pulse = 0;
    logic               m_ldp = 0;

    // galois lfsr, one step per bit taken
    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // random mac address, upper bits drawn first
    function xpu_pkg::mac_addr_t draw_mac();
        logic [15:0] hi;
        logic [31:0] lo;
        hi = rand_bits(16);
        lo = rand_bits(32);
        return {hi, lo};
    endfunction

    task fail_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        n_errors++;
        $display("** Error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    endtask

    task check_fc(input xpu_pkg::fc_word_u got, input xpu_pkg::fc_word_u exp);
        n_checks++;
        if (got.raw !== exp.raw) begin
            fail_value("fc raw", got.raw, exp.raw);
        end
        if (got.fields.ftype !== exp.fields.ftype || got.fields.subtype !== exp.fields.subtype
            || got.fields.to_ds !== exp.fields.to_ds
            || got.fields.duration !== exp.fields.duration) begin
            fail_value("fc fields", got.fields, exp.fields);
        end
    endtask

    task check_addr(input xpu_pkg::mac_addr_t got, input xpu_pkg::mac_addr_t exp,
                    input string what);
        n_checks++;
        if (got !== exp) begin
            fail_value(what, got, exp);
        end
    endtask

    task check_verdict(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            fail_value(what, got, exp);
        end
    endtask

    task check_tsf(input xpu_pkg::tsf_t got, input xpu_pkg::tsf_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            fail_value(what, got, exp);
        end
    endtask

    task check_count(input int got, input int exp, input string what);
        n_checks++;
        if (got != exp) begin
            fail_value(what, got, exp);
        end
    endtask

    // advance one clock, predict this edge and compare
    task next_cycle;
        logic s_rs, s_hs, s_bs, s_fs, s_ok, s_ld, clr, decide, rep_block;
        logic ev_fc, ev_a1, ev_a2, ev_a3, ev_vv, ev_rv;
        logic [`XPU_BYTE_IDX_W-1:0] s_idx;
        xpu_pkg::tsf_t s_ldv;
        @(posedge clk);
        s_rs = reset_i;
        s_hs = header_strobe_i;
        s_bs = byte_strobe_i;
        s_idx = byte_index_i;
        s_fs = fcs_strobe_i;
        s_ok = fcs_ok_i;
        s_ld = tsf_load_i;
        s_ldv = tsf_load_val_i;
        #0.5;
        cycle++;
        clr = s_rs || s_hs;
        ev_fc = !clr && s_bs && (s_idx == `XPU_FC_LAST);
        ev_a1 = !clr && s_bs && (s_idx == `XPU_ADDR1_LAST);
        ev_a2 = !clr && s_bs && (s_idx == `XPU_ADDR2_LAST);
        ev_a3 = !clr && s_bs && (s_idx == `XPU_ADDR3_LAST);
        ev_vv = !clr && m_vv_pend;
        ev_rv = !s_rs && s_fs;
        rep_block = m_has_verdict ? m_vblock : 1'b1;
        if (s_hs) begin
            m_stamp = m_tsf;
        end
        // microsecond timer
        if (s_rs) begin
            m_tsf = '0;
            m_div = 0;
            m_pulse = 0;
            m_ldp = 0;
        end else begin
            if (s_ld && !m_ldp) begin
                m_tsf = s_ldv;
                m_div = 0;
                m_pulse = 0;
            end else if (m_div == `XPU_CLK_PER_US - 1) begin
                m_div = 0;
                m_tsf = m_tsf + 1;
                m_pulse = 1;
            end else begin
                m_div++;
                m_pulse = 0;
            end
            m_ldp = s_ld;
        end
        check_verdict(fc_valid_o, ev_fc, "fc_valid");
        check_verdict(addr1_valid_o, ev_a1, "addr1_valid");
        check_verdict(addr2_valid_o, ev_a2, "addr2_valid");
        check_verdict(addr3_valid_o, ev_a3, "addr3_valid");
        check_verdict(verdict_valid_o, ev_vv, "verdict_valid");
        check_verdict(report_valid_o, ev_rv, "report_valid");
        check_verdict(tsf_pulse_o, m_pulse, "tsf_pulse");
        check_tsf(tsf_o, m_tsf, "tsf");
        if (ev_fc) check_fc(fc_o, f_fc);
        if (ev_a1) check_addr(addr1_o, f_a1, "addr1");
        if (ev_a2) check_addr(addr2_o, f_a2, "addr2");
        if (ev_a3) check_addr(addr3_o, f_a3, "addr3");
        if (ev_vv) check_verdict(verdict_block_o, f_block, "verdict_block");
        if (ev_rv) begin
            check_verdict(report_ok_o, s_ok, "report_ok");
            check_verdict(report_block_o, rep_block, "report_block");
            check_tsf(report_tsf_o, m_stamp, "report_tsf");
        end
        if (clr) begin
            m_fc_seen = 0;
            m_is_ctrl = 0;
            m_decided = 0;
            m_vv_pend = 0;
            m_has_verdict = 0;
            m_a1_seen = 0;
        end else begin
            if (ev_vv) begin
                m_has_verdict = 1;
                m_vblock = f_block;
            end
            // control frames are decided on addr1, the rest on addr3
            decide = m_fc_seen && !m_decided && (m_is_ctrl ? ev_a1 : ev_a3);
            m_vv_pend = decide;
            if (decide) m_decided = 1;
            if (ev_fc) begin
                m_fc_seen = 1;
                m_is_ctrl = (f_fc.fields.ftype == xpu_pkg::ft_ctrl);
            end
            if (ev_a1) begin
                m_a1_seen = 1;
                m_a1 = f_a1;
            end
        end
        check_verdict(pkt_for_me_o, m_a1_seen && (m_a1 == self_mac_i), "pkt_for_me");
    endtask

    // mode 0 random, 1 over-length, 2 truncated header
    task send_frame(input int mode);
        logic [1:0] t;
        logic       acc;
        int         n_bytes;
        int         gap;
        logic [7:0] b;
        filter_cfg_i = rand_bits(6);
        self_mac_i = draw_mac();
        self_bssid_i = draw_mac();
        max_len_i = 24 + rand_bits(5);
        pkt_len_i = (mode == 1) ? max_len_i + 1 + rand_bits(3) : 22 + rand_bits(5);
        f_fc.raw = rand_bits(32);
        t = rand_bits(2);
        f_fc.fields.ftype = (t == 2'b11) ? xpu_pkg::ft_mgmt : xpu_pkg::frame_type_e'(t);
        f_fc.fields.version = 2'b00;
        if (f_fc.fields.ftype == xpu_pkg::ft_mgmt && rand_bits(1)) begin
            f_fc.fields.subtype = xpu_pkg::subtype_beacon;
        end
        case (rand_bits(2))
            0: f_a1 = self_mac_i;
            1: f_a1 = '1;
            default: f_a1 = draw_mac();
        endcase
        f_a2 = draw_mac();
        f_a3 = rand_bits(1) ? self_bssid_i : draw_mac();
        acc = filter_cfg_i[0]
              || (filter_cfg_i[1] && f_a1 == self_mac_i)
              || (filter_cfg_i[2] && f_a1 == 48'hFFFF_FFFF_FFFF)
              || (filter_cfg_i[3] && f_fc.fields.ftype == xpu_pkg::ft_mgmt
                  && f_fc.fields.subtype == 4'b1000 && f_a3 == self_bssid_i)
              || (filter_cfg_i[4] && f_fc.fields.ftype == xpu_pkg::ft_ctrl)
              || (filter_cfg_i[5] && f_fc.fields.ftype == xpu_pkg::ft_data
                  && (f_fc.fields.to_ds || f_fc.fields.from_ds));
        f_block = !acc || (pkt_len_i > max_len_i);
        n_bytes = (mode == 2) ? 1 + rand_bits(4) + rand_bits(2) : 22 + rand_bits(2);
        header_strobe_i = 1'b1;
        next_cycle();
        header_strobe_i = 1'b0;
        for (int i = 0; i < n_bytes; i++) begin
            gap = rand_bits(2);
            for (int g = 0; g < gap; g++) next_cycle();
            if (i <= `XPU_FC_LAST) b = f_fc.raw[8*i +: 8];
            else if (i <= `XPU_ADDR1_LAST) b = f_a1[8*(i-4) +: 8];
            else if (i <= `XPU_ADDR2_LAST) b = f_a2[8*(i-10) +: 8];
            else if (i <= `XPU_ADDR3_LAST) b = f_a3[8*(i-16) +: 8];
            else b = rand_bits(8);
            byte_strobe_i = 1'b1;
            byte_i = b;
            byte_index_i = i;
            next_cycle();
            byte_strobe_i = 1'b0;
        end
        next_cycle();
        next_cycle();
        fcs_strobe_i = 1'b1;
        fcs_ok_i = rand_bits(1);
        next_cycle();
        fcs_strobe_i = 1'b0;
        next_cycle();
        next_cycle();
    endtask

    task run_frames(input int mode, input string name);
        int e0;
        int c0;
        e0 = n_errors;
        c0 = n_checks;
        for (int i = 0; i < n_frames; i++) send_frame(mode);
        n_tests++;
        $display("test %s: %0d checks, %0d errors", name, n_checks - c0, n_errors - e0);
    endtask

    // tick spacing and load on the rising edge of the load level
    task run_tsf;
        int e0;
        int c0;
        int last;
        e0 = n_errors;
        c0 = n_checks;
        last = -1;
        tsf_load_val_i = {rand_bits(32), rand_bits(32)};
        tsf_load_i = 1'b1;
        for (int i = 0; i < 5; i++) next_cycle();
        tsf_load_i = 1'b0;
        for (int i = 0; i < 350; i++) begin
            next_cycle();
            if (tsf_pulse_o) begin
                if (last >= 0) check_count(cycle - last, `XPU_CLK_PER_US, "tick spacing");
                last = cycle;
            end
        end
        tsf_load_val_i = {rand_bits(32), rand_bits(32)};
        tsf_load_i = 1'b1;
        next_cycle();
        tsf_load_i = 1'b0;
        for (int i = 0; i < 250; i++) next_cycle();
        n_tests++;
        $display("test tsf timer: %0d checks, %0d errors", n_checks - c0, n_errors - e0);
    endtask

    initial begin
        reset_i = 1'b1;
        header_strobe_i = 1'b0;
        pkt_len_i = '0;
        byte_strobe_i = 1'b0;
        byte_i = '0;
        byte_index_i = '0;
        fcs_strobe_i = 1'b0;
        fcs_ok_i = 1'b0;
        self_mac_i = '0;
        self_bssid_i = '0;
        filter_cfg_i = '0;
        max_len_i = '0;
        tsf_load_i = 1'b0;
        tsf_load_val_i = '0;
        next_cycle();
        next_cycle();
        reset_i = 1'b0;
        run_frames(0, "random frames");
        run_frames(1, "over-length frames");
        run_frames(2, "truncated frames");
        run_tsf();
        // failures of the bound strobe assertions
        n_assert_fails = i_xpu_rx.i_header_parse.i_parse_props.fail_count
                         + i_xpu_rx.i_frame_filter.i_filter_props.fail_count
                         + i_xpu_rx.i_frame_report.i_report_props.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, n_checks, n_errors, n_assert_fails);
        if (n_errors == 0 && n_assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

endmodule

/* sim/xpu_rx_properties.sv */
// xpu receive strobe assertions
`timescale 1ns/1ps

module xpu_rx_properties (
    input logic       clk,
    input logic       reset_i,
    input logic       header_strobe_i,
    input logic [3:0] pulse_i,
    input logic       once_i,
    input logic       trig_i,
    input logic       resp_i
);

    logic once_seen_q;

    // assertion failures seen by this instance
    int   fail_count = 0;

    // verdicts issued since the last header
    always_ff @(posedge clk) begin
        if (reset_i || header_strobe_i) begin
            once_seen_q <= 1'b0;
        end else if (once_i) begin
            once_seen_q <= 1'b1;
        end
    end

    genvar k;
    generate
        for (k = 0; k < 4; k++) begin : g_pulse
            a_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
                pulse_i[k] |=> !pulse_i[k])
                else begin
                    fail_count++;
                    $error("valid held for more than one cycle");
                end
        end
    endgenerate

    a_one_per_header: assert property (@(posedge clk) disable iff (reset_i)
        once_i |-> !once_seen_q)
        else begin
            fail_count++;
            $error("second verdict for one header");
        end

    a_follows_by_one: assert property (@(posedge clk) disable iff (reset_i)
        trig_i |=> resp_i)
        else begin
            fail_count++;
            $error("report missing one cycle after fcs strobe");
        end

endmodule

bind rx_header_parse xpu_rx_properties i_parse_props (
    .clk             (clk),
    .reset_i         (reset_i),
    .header_strobe_i (header_strobe_i),
    .pulse_i         ({fc_valid_o, addr1_valid_o, addr2_valid_o, addr3_valid_o}),
    .once_i          (1'b0),
    .trig_i          (1'b0),
    .resp_i          (1'b0)
);

bind rx_frame_filter xpu_rx_properties i_filter_props (
    .clk             (clk),
    .reset_i         (reset_i),
    .header_strobe_i (header_strobe_i),
    .pulse_i         ({3'b000, verdict_valid_o}),
    .once_i          (verdict_valid_o),
    .trig_i          (1'b0),
    .resp_i          (1'b0)
);

bind rx_frame_report xpu_rx_properties i_report_props (
    .clk             (clk),
    .reset_i         (reset_i),
    .header_strobe_i (header_strobe_i),
    .pulse_i         ({3'b000, report_valid_o}),
    .once_i          (1'b0),
    .trig_i          (fcs_strobe_i),
    .resp_i          (report_valid_o)
);

/* hw/xpu_rx.sv */
// xpu receive path top level
`timescale 1ns/1ps
`include "xpu_defs.svh"

module xpu_rx (
    input  logic                       clk,
    input  logic                       reset_i,
    // from the ofdm receiver
    input  logic                       header_strobe_i,
    input  logic [`XPU_BYTE_IDX_W-1:0] pkt_len_i,
    input  logic                       byte_strobe_i,
    input  logic [7:0]                 byte_i,
    input  logic [`XPU_BYTE_IDX_W-1:0] byte_index_i,
    input  logic                       fcs_strobe_i,
    input  logic                       fcs_ok_i,
    // configuration levels
    input  xpu_pkg::mac_addr_t         self_mac_i,
    input  xpu_pkg::mac_addr_t         self_bssid_i,
    input  logic [`XPU_FILTER_W-1:0]   filter_cfg_i,
    input  logic [`XPU_BYTE_IDX_W-1:0] max_len_i,
    input  logic                       tsf_load_i,
    input  xpu_pkg::tsf_t              tsf_load_val_i,
    // decoded header
    output xpu_pkg::fc_word_u          fc_o,
    output logic                       fc_valid_o,
    output xpu_pkg::mac_addr_t         addr1_o,
    output xpu_pkg::mac_addr_t         addr2_o,
    output xpu_pkg::mac_addr_t         addr3_o,
    output logic                       addr1_valid_o,
    output logic                       addr2_valid_o,
    output logic                       addr3_valid_o,
    // filter and report
    output logic                       verdict_valid_o,
    output logic                       verdict_block_o,
    output logic                       pkt_for_me_o,
    output logic                       report_valid_o,
    output logic                       report_ok_o,
    output logic                       report_block_o,
    output xpu_pkg::tsf_t              report_tsf_o,
    output xpu_pkg::tsf_t              tsf_o,
    output logic                       tsf_pulse_o
);

    rx_header_parse i_header_parse (
        .clk             (clk),
        .reset_i         (reset_i),
        .header_strobe_i (header_strobe_i),
        .byte_strobe_i   (byte_strobe_i),
        .byte_i          (byte_i),
        .byte_index_i    (byte_index_i),
        .fc_o            (fc_o),
        .fc_valid_o      (fc_valid_o),
        .addr1_o         (addr1_o),
        .addr2_o         (addr2_o),
        .addr3_o         (addr3_o),
        .addr1_valid_o   (addr1_valid_o),
        .addr2_valid_o   (addr2_valid_o),
        .addr3_valid_o   (addr3_valid_o)
    );

    rx_frame_filter i_frame_filter (
        .clk             (clk),
        .reset_i         (reset_i),
        .header_strobe_i (header_strobe_i),
        .pkt_len_i       (pkt_len_i),
        .fc_i            (fc_o),
        .fc_valid_i      (fc_valid_o),
        .addr1_i         (addr1_o),
        .addr1_valid_i   (addr1_valid_o),
        .addr3_i         (addr3_o),
        .addr3_valid_i   (addr3_valid_o),
        .self_mac_i      (self_mac_i),
        .self_bssid_i    (self_bssid_i),
        .filter_cfg_i    (filter_cfg_i),
        .max_len_i       (max_len_i),
        .verdict_valid_o (verdict_valid_o),
        .verdict_block_o (verdict_block_o),
        .pkt_for_me_o    (pkt_for_me_o)
    );

    rx_frame_report i_frame_report (
        .clk             (clk),
        .reset_i         (reset_i),
        .header_strobe_i (header_strobe_i),
        .tsf_i           (tsf_o),
        .verdict_valid_i (verdict_valid_o),
        .verdict_block_i (verdict_block_o),
        .fcs_strobe_i    (fcs_strobe_i),
        .fcs_ok_i        (fcs_ok_i),
        .report_valid_o  (report_valid_o),
        .report_ok_o     (report_ok_o),
        .report_block_o  (report_block_o),
        .report_tsf_o    (report_tsf_o)
    );

    tsf_timer i_tsf_timer (
        .clk            (clk),
        .reset_i        (reset_i),
        .tsf_load_i     (tsf_load_i),
        .tsf_load_val_i (tsf_load_val_i),
        .tsf_o          (tsf_o),
        .tsf_pulse_o    (tsf_pulse_o)
    );

endmodule

/* hw/tsf_timer.sv */
// tsf microsecond timer
`timescale 1ns/1ps
`include "xpu_defs.svh"

module tsf_timer (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          tsf_load_i,
    input  xpu_pkg::tsf_t tsf_load_val_i,
    output xpu_pkg::tsf_t tsf_o,
    output logic          tsf_pulse_o
);

    localparam int div_w = $clog2(`XPU_CLK_PER_US + 1);
    localparam logic [div_w-1:0] div_top = div_w'(`XPU_CLK_PER_US - 1);

    logic [div_w-1:0] div_q;
    logic             load_q;
    logic             load_rise;

    // load acts on the rising edge of the level only
    assign load_rise = tsf_load_i && !load_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            load_q <= 1'b0;
        end else begin
            load_q <= tsf_load_i;
        end
    end

    // divider and counter, the count steps together with the tick
    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_q       <= '0;
            tsf_o       <= '0;
            tsf_pulse_o <= 1'b0;
        end else if (load_rise) begin
            // restart the microsecond from the loaded value
            div_q       <= '0;
            tsf_o       <= tsf_load_val_i;
            tsf_pulse_o <= 1'b0;
        end else if (div_q == div_top) begin
            div_q       <= '0;
            tsf_o       <= tsf_o + 1'b1;
            tsf_pulse_o <= 1'b1;
        end else begin
            div_q       <= div_q + 1'b1;
            tsf_pulse_o <= 1'b0;
        end
    end

endmodule

/* hw/rx_frame_report.sv */
// receive frame reporter
`timescale 1ns/1ps

module rx_frame_report (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          header_strobe_i,
    input  xpu_pkg::tsf_t tsf_i,
    input  logic          verdict_valid_i,
    input  logic          verdict_block_i,
    input  logic          fcs_strobe_i,
    input  logic          fcs_ok_i,
    output logic          report_valid_o,
    output logic          report_ok_o,
    output logic          report_block_o,
    output xpu_pkg::tsf_t report_tsf_o
);

    xpu_pkg::tsf_t stamp_q;
    logic          judged_q;
    logic          block_q;

    // timestamp taken at the start of the frame
    always_ff @(posedge clk) begin
        if (header_strobe_i) begin
            stamp_q <= tsf_i;
        end
    end

    // whether the filter has judged this frame yet
    always_ff @(posedge clk) begin
        if (reset_i || header_strobe_i) begin
            judged_q <= 1'b0;
        end else if (verdict_valid_i) begin
            judged_q <= 1'b1;
            block_q  <= verdict_block_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            report_valid_o <= 1'b0;
        end else begin
            report_valid_o <= fcs_strobe_i;
        end
    end

    // truncated frames never got a verdict, so they go out blocked
    always_ff @(posedge clk) begin
        if (fcs_strobe_i) begin
            report_ok_o    <= fcs_ok_i;
            report_tsf_o   <= stamp_q;
            report_block_o <= verdict_valid_i ? verdict_block_i
                                              : (!judged_q || block_q);
        end
    end

endmodule

/* hw/rx_frame_filter.sv */
// receive frame filter
`timescale 1ns/1ps
`include "xpu_defs.svh"

module rx_frame_filter (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       header_strobe_i,
    input  logic [`XPU_BYTE_IDX_W-1:0] pkt_len_i,
    input  xpu_pkg::fc_word_u          fc_i,
    input  logic                       fc_valid_i,
    input  xpu_pkg::mac_addr_t         addr1_i,
    input  logic                       addr1_valid_i,
    input  xpu_pkg::mac_addr_t         addr3_i,
    input  logic                       addr3_valid_i,
    input  xpu_pkg::mac_addr_t         self_mac_i,
    input  xpu_pkg::mac_addr_t         self_bssid_i,
    input  logic [`XPU_FILTER_W-1:0]   filter_cfg_i,
    input  logic [`XPU_BYTE_IDX_W-1:0] max_len_i,
    output logic                       verdict_valid_o,
    output logic                       verdict_block_o,
    output logic                       pkt_for_me_o
);

    logic [`XPU_BYTE_IDX_W-1:0] len_q;
    logic                       fc_seen_q;
    logic                       addr1_seen_q;
    logic                       decided_q;
    logic                       is_ctrl_q;
    logic                       is_beacon_q;
    logic                       is_data_ds_q;
    logic                       addr1_is_me;
    logic                       decide;
    logic [`XPU_FILTER_W-1:0]   rule_hit;
    logic                       accept;

    assign addr1_is_me = (addr1_i == self_mac_i);

    // me-flag holds from the addr1 pulse to the next header
    assign pkt_for_me_o = (addr1_valid_i || addr1_seen_q) && addr1_is_me;

    // control frames carry no addr3, so they are judged on addr1
    assign decide = fc_seen_q && !decided_q
                    && (is_ctrl_q ? addr1_valid_i : addr3_valid_i);

    assign rule_hit[0] = filter_cfg_i[0];
    assign rule_hit[1] = filter_cfg_i[1] && addr1_is_me;
    assign rule_hit[2] = filter_cfg_i[2] && (addr1_i == '1);
    assign rule_hit[3] = filter_cfg_i[3] && is_beacon_q && (addr3_i == self_bssid_i);
    assign rule_hit[4] = filter_cfg_i[4] && is_ctrl_q;
    assign rule_hit[5] = filter_cfg_i[5] && is_data_ds_q;

    assign accept = |rule_hit;

    // length as signalled at the header
    always_ff @(posedge clk) begin
        if (header_strobe_i) begin
            len_q <= pkt_len_i;
        end
    end

    // per-frame flags
    always_ff @(posedge clk) begin
        if (reset_i || header_strobe_i) begin
            fc_seen_q    <= 1'b0;
            addr1_seen_q <= 1'b0;
            is_ctrl_q    <= 1'b0;
            is_beacon_q  <= 1'b0;
            is_data_ds_q <= 1'b0;
        end else begin
            if (fc_valid_i) begin
                fc_seen_q    <= 1'b1;
                is_ctrl_q    <= (fc_i.fields.ftype == xpu_pkg::ft_ctrl);
                is_beacon_q  <= (fc_i.fields.ftype == xpu_pkg::ft_mgmt)
                                && (fc_i.fields.subtype == xpu_pkg::subtype_beacon);
                is_data_ds_q <= (fc_i.fields.ftype == xpu_pkg::ft_data)
                                && (fc_i.fields.to_ds || fc_i.fields.from_ds);
            end
            if (addr1_valid_i) begin
                addr1_seen_q <= 1'b1;
            end
        end
    end

    // at most one verdict between headers
    always_ff @(posedge clk) begin
        if (reset_i || header_strobe_i) begin
            decided_q       <= 1'b0;
            verdict_valid_o <= 1'b0;
        end else begin
            verdict_valid_o <= decide;
            if (decide) begin
                decided_q <= 1'b1;
            end
        end
    end

    // over-length frames are blocked whatever the rules say
    always_ff @(posedge clk) begin
        if (decide) begin
            verdict_block_o <= !accept || (len_q > max_len_i);
        end
    end

endmodule

/* hw/rx_header_parse.sv */
// 802.11 header field parser
`timescale 1ns/1ps
`include "xpu_defs.svh"

module rx_header_parse (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       header_strobe_i,
    input  logic                       byte_strobe_i,
    input  logic [7:0]                 byte_i,
    input  logic [`XPU_BYTE_IDX_W-1:0] byte_index_i,
    output xpu_pkg::fc_word_u          fc_o,
    output logic                       fc_valid_o,
    output xpu_pkg::mac_addr_t         addr1_o,
    output xpu_pkg::mac_addr_t         addr2_o,
    output xpu_pkg::mac_addr_t         addr3_o,
    output logic                       addr1_valid_o,
    output logic                       addr2_valid_o,
    output logic                       addr3_valid_o
);

    localparam logic [`XPU_BYTE_IDX_W-1:0] fc_last    = `XPU_FC_LAST;
    localparam logic [`XPU_BYTE_IDX_W-1:0] addr1_last = `XPU_ADDR1_LAST;
    localparam logic [`XPU_BYTE_IDX_W-1:0] addr2_last = `XPU_ADDR2_LAST;
    localparam logic [`XPU_BYTE_IDX_W-1:0] addr3_last = `XPU_ADDR3_LAST;

    logic in_fc;
    logic in_addr1;
    logic in_addr2;
    logic in_addr3;

    // bytes arrive lsb first, so each new byte enters at the top
    function automatic xpu_pkg::mac_addr_t shift_addr(
        input xpu_pkg::mac_addr_t cur,
        input logic [7:0]         b
    );
        return {b, cur[`XPU_ADDR_W-1:8]};
    endfunction

    // field select from the byte index
    assign in_fc    = byte_strobe_i && (byte_index_i <= fc_last);
    assign in_addr1 = byte_strobe_i && (byte_index_i > fc_last)
                      && (byte_index_i <= addr1_last);
    assign in_addr2 = byte_strobe_i && (byte_index_i > addr1_last)
                      && (byte_index_i <= addr2_last);
    assign in_addr3 = byte_strobe_i && (byte_index_i > addr2_last)
                      && (byte_index_i <= addr3_last);

    // field shift registers, held until the next header
    always_ff @(posedge clk) begin
        if (header_strobe_i) begin
            fc_o.raw <= '0;
            addr1_o  <= '0;
            addr2_o  <= '0;
            addr3_o  <= '0;
        end else begin
            if (in_fc) begin
                fc_o.raw <= {byte_i, fc_o.raw[`XPU_FC_W-1:8]};
            end
            if (in_addr1) begin
                addr1_o <= shift_addr(addr1_o, byte_i);
            end
            if (in_addr2) begin
                addr2_o <= shift_addr(addr2_o, byte_i);
            end
            if (in_addr3) begin
                addr3_o <= shift_addr(addr3_o, byte_i);
            end
        end
    end

    // one pulse per field, the cycle after its last byte
    always_ff @(posedge clk) begin
        if (reset_i || header_strobe_i) begin
            fc_valid_o    <= 1'b0;
            addr1_valid_o <= 1'b0;
            addr2_valid_o <= 1'b0;
            addr3_valid_o <= 1'b0;
        end else begin
            fc_valid_o    <= byte_strobe_i && (byte_index_i == fc_last);
            addr1_valid_o <= byte_strobe_i && (byte_index_i == addr1_last);
            addr2_valid_o <= byte_strobe_i && (byte_index_i == addr2_last);
            addr3_valid_o <= byte_strobe_i && (byte_index_i == addr3_last);
        end
    end

endmodule

/* hw/xpu_pkg.sv */
// xpu receive path types
`include "xpu_defs.svh"

package xpu_pkg;

    typedef logic [`XPU_ADDR_W-1:0] mac_addr_t;

    typedef logic [`XPU_TSF_W-1:0] tsf_t;

    // 802.11 frame type codes
    typedef enum logic [1:0] {
        ft_mgmt = 2'b00,
        ft_ctrl = 2'b01,
        ft_data = 2'b10
    } frame_type_e;

    localparam logic [3:0] subtype_beacon = 4'b1000;

    // first member is the msb, so duration sits in the upper half
    typedef struct packed {
        logic [15:0] duration;
        logic        order;
        logic        protected_frame;
        logic        more_data;
        logic        power_manage;
        logic        retry;
        logic        more_frag;
        logic        from_ds;
        logic        to_ds;
        logic [3:0]  subtype;
        frame_type_e ftype;
        logic [1:0]  version;
    } fc_fields_t;

    typedef union packed {
        logic [`XPU_FC_W-1:0] raw;
        fc_fields_t           fields;
    } fc_word_u;

endpackage

/* hw/xpu_defs.svh */
// xpu receive path constants
`ifndef XPU_DEFS_SVH
`define XPU_DEFS_SVH

// mac address width
`define XPU_ADDR_W 48

// frame control plus duration, as the header carries them
`define XPU_FC_W 32

// byte index and length counters
`define XPU_BYTE_IDX_W 16

// last byte of each header field, counted from the first header byte
`define XPU_FC_LAST 3
`define XPU_ADDR1_LAST 9
`define XPU_ADDR2_LAST 15
`define XPU_ADDR3_LAST 21

// tsf timer
`define XPU_TSF_W 64
`define XPU_CLK_PER_US 100

// one enable bit per filter rule
`define XPU_FILTER_W 6

`endif
